//--- compile.f
procIsaPkg.sv
procPipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
proc.sv
proc_props.sv
procTb.sv

//--- run.sh
#!/bin/sh
# Builds the processor testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module procTb -f compile.f
output=$(./obj_dir/VprocTb +verilator+error+limit+1000)
echo "$output"
if echo "$output" | grep -qx "=== PASS ==="; then
   exit 0
fi
exit 1

//--- procTb.sv
/*
 * Testbench for the pipelined processor. Loads generated programs while
 * reset is held, predicts the register writes with an instruction-level
 * model and checks every retire against that prediction.
 */
`timescale 1ns/1ps
module procTb;

   typedef struct packed {
      procIsaPkg::regIdx r;
      procIsaPkg::word   d;
   } retireEntry;

   logic              clk;
   logic              reset;
   logic              progWrite;
   procIsaPkg::pcAddr progAddr;
   procIsaPkg::word   progData;
   logic              retireValid;
   procIsaPkg::regIdx retireReg;
   procIsaPkg::word   retireData;
   logic              halted;
   logic              err;

   integer            seed = 85698;
   procIsaPkg::word   prog[$];
   retireEntry        expected[$];
   logic              expectErr;
   int                errors = 0;
   int                timeouts = 0;

   proc DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int randBelow(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Half the time reuse the last result to force back-to-back hazards
   function automatic int pickSource(input int lastRd);
      if ($random(seed) & 1) begin
         return lastRd;
      end
      return randBelow(8);
   endfunction

   function automatic procIsaPkg::word regForm(input logic [3:0] op, input int rd,
      input int rs, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   function automatic procIsaPkg::word immForm(input logic [3:0] op, input int rd,
      input int rs, input int imm);
      return {op, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   function automatic procIsaPkg::word loadImm(input int rd, input int imm);
      return {procIsaPkg::LI, 3'(rd), 1'b0, 8'(imm)};
   endfunction

   task automatic randomProgram(input int len, input bit withMem, input bit withIllegal);
      int lastRd;
      int rd;
      int kind;
      int off;
      int badAt;
      logic [7:0] written;
      prog.delete();
      for (int r = 0; r < 8; r++) begin
         prog.push_back(loadImm(r, randBelow(256)));
      end
      lastRd = 0;
      written = '0;
      badAt = withIllegal ? randBelow(len) : -1;
      for (int i = 0; i < len; i++) begin
         kind = randBelow(withMem ? 8 : 6);
         // r7 keeps the memory base in memory programs
         rd = randBelow(withMem ? 7 : 8);
         if (i == badAt) begin
            prog.push_back({4'(10 + randBelow(6)), 12'(randBelow(4096))});
         end else if (kind < 4) begin
            prog.push_back(regForm(4'(kind), rd, pickSource(lastRd), pickSource(lastRd)));
            lastRd = rd;
         end else if (kind == 4) begin
            prog.push_back(immForm(procIsaPkg::ADDI, rd, pickSource(lastRd), randBelow(64)));
            lastRd = rd;
         end else if (kind == 5) begin
            prog.push_back(loadImm(rd, randBelow(256)));
            lastRd = rd;
         end else begin
            off = randBelow(8);
            // Loads only read slots this program has stored to
            if (kind == 7 && written[off]) begin
               prog.push_back(immForm(procIsaPkg::LD, rd, 7, off));
               lastRd = rd;
            end else begin
               prog.push_back(immForm(procIsaPkg::ST, pickSource(lastRd), 7, off));
               written[off] = 1'b1;
            end
         end
      end
      prog.push_back({procIsaPkg::HALT, 12'h000});
   endtask

   task automatic countingLoop();
      prog.delete();
      prog.push_back(loadImm(0, 0));
      prog.push_back(loadImm(1, 1 + randBelow(6)));
      prog.push_back(loadImm(2, 0));
      // Exit test, goes to 10 once r1 reaches zero
      prog.push_back(immForm(procIsaPkg::BEQZ, 0, 1, 6));
      prog.push_back(immForm(procIsaPkg::ADDI, 1, 1, -1));
      prog.push_back(immForm(procIsaPkg::ADDI, 2, 2, 1 + randBelow(7)));
      prog.push_back(regForm(procIsaPkg::XOR, 4, 2, 1));
      // r0 stays zero so this always jumps back to 3
      prog.push_back(immForm(procIsaPkg::BEQZ, 0, 0, -5));
      prog.push_back(loadImm(5, 8'hAA));
      prog.push_back(immForm(procIsaPkg::ADDI, 6, 0, 1));
      prog.push_back(regForm(procIsaPkg::ADD, 7, 2, 4));
      prog.push_back({procIsaPkg::HALT, 12'h000});
   endtask

   // Instruction-level model, one instruction per step in program order
   task automatic runModel();
      procIsaPkg::word r [8];
      procIsaPkg::word mem [256];
      procIsaPkg::word ins;
      procIsaPkg::word a;
      procIsaPkg::word b;
      procIsaPkg::word v;
      procIsaPkg::word sImm;
      logic            wr;
      int              pc;
      expected.delete();
      expectErr = 1'b0;
      pc = 0;
      for (int step = 0; step < 1000; step++) begin
         ins = prog[pc];
         a = r[ins[8:6]];
         b = r[ins[5:3]];
         sImm = {{10{ins[5]}}, ins[5:0]};
         wr = 1'b1;
         pc = (pc + 1) & 255;
         case (ins[15:12])
            procIsaPkg::ADD:  v = a + b;
            procIsaPkg::SUB:  v = a - b;
            procIsaPkg::AND:  v = a & b;
            procIsaPkg::XOR:  v = a ^ b;
            procIsaPkg::ADDI: v = a + sImm;
            procIsaPkg::LI:   v = {8'h00, ins[7:0]};
            procIsaPkg::LD:   v = mem[8'(a + sImm)];
            procIsaPkg::ST: begin
               mem[8'(a + sImm)] = r[ins[11:9]];
               wr = 1'b0;
            end
            procIsaPkg::BEQZ: begin
               if (a == 0) begin
                  pc = (pc + sImm) & 255;
               end
               wr = 1'b0;
            end
            procIsaPkg::HALT: break;
            default: begin
               expectErr = 1'b1;
               wr = 1'b0;
            end
         endcase
         if (wr) begin
            r[ins[11:9]] = v;
            expected.push_back(retireEntry'{ins[11:9], v});
         end
      end
   endtask

   task automatic runProgram(input string name);
      retireEntry want;
      int         cycles;
      runModel();
      reset = 1'b1;
      repeat (4) @(negedge clk);
      // Program goes in while reset is still held
      foreach (prog[i]) begin
         progWrite = 1'b1;
         progAddr = procIsaPkg::pcAddr'(i);
         progData = prog[i];
         @(negedge clk);
      end
      progWrite = 1'b0;
      reset = 1'b0;
      cycles = 0;
      while (!halted && cycles < 10 * prog.size() + 50) begin
         @(negedge clk);
         cycles++;
         if (retireValid) begin
            assert (expected.size() > 0) else begin
               $display("FAIL at %0t: %s retired r%0d = %h with nothing expected",
                  $time, name, retireReg, retireData);
               errors++;
            end
            if (expected.size() > 0) begin
               want = expected.pop_front();
               assert (retireReg == want.r && retireData == want.d) else begin
                  $display("FAIL at %0t: %s retired r%0d = %h, expected r%0d = %h",
                     $time, name, retireReg, retireData, want.r, want.d);
                  errors++;
               end
            end
         end
      end
      if (!halted) begin
         $display("Timeout: the processor never halted in a %s program", name);
         timeouts++;
      end
      assert (expected.size() == 0) else begin
         $display("FAIL at %0t: %s program ended with %0d writes never retired",
            $time, name, expected.size());
         errors++;
      end
      assert (err == expectErr) else begin
         $display("FAIL at %0t: %s program left err = %b, expected %b",
            $time, name, err, expectErr);
         errors++;
      end
      // Idle so the halted level is seen holding
      repeat (3) @(negedge clk);
   endtask

   initial begin
      reset = 1'b1;
      progWrite = 1'b0;
      progAddr = '0;
      progData = '0;
      @(negedge clk);
      repeat (4) begin
         randomProgram(24, 1'b0, 1'b0);
         runProgram("ALU");
      end
      repeat (4) begin
         randomProgram(24, 1'b1, 1'b0);
         runProgram("memory");
      end
      repeat (3) begin
         countingLoop();
         runProgram("loop");
      end
      // An illegal opcode stays in instruction memory, so these come last
      repeat (2) begin
         randomProgram(16, 1'b1, 1'b1);
         runProgram("illegal");
      end
      reset = 1'b1;
      repeat (4) @(negedge clk);
      $display("Errors: %0d retire or state, %0d timeout, %0d property",
         errors, timeouts, DUT.propsCheck.failures);
      if (errors + timeouts + DUT.propsCheck.failures == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- proc_props.sv
/*
 * Concurrent checks on the processor's control outputs, bound into proc
 * at the end of this file. Covers reset values, halt and the err flag.
 */
`timescale 1ns/1ps
module procProps (
   input wire                clk,
   input wire                reset,
   input wire                progWrite,
   input procIsaPkg::pcAddr  progAddr,
   input procIsaPkg::word    progData,
   input wire                retireValid,
   input wire                halted,
   input wire                err
);

   logic [procIsaPkg::IMEM_DEPTH-1:0] illegalAt = '0;
   int unsigned                       failures = 0;

   // Slots currently holding an undefined opcode
   always_ff @(posedge clk) begin
      if (progWrite) begin
         illegalAt[progAddr] <=
            progData[procIsaPkg::OP_HI:procIsaPkg::OP_LO] > procIsaPkg::HALT;
      end
   end

   resetClears: assert property (@(posedge clk) reset |=> !retireValid && !halted && !err)
      else begin
         $error("retireValid, halted or err high after a reset cycle");
         failures++;
      end

   noRetireInReset: assert property (@(posedge clk) reset |-> !$rose(retireValid))
      else begin
         $error("retireValid rose while reset was high");
         failures++;
      end

   haltHolds: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else begin
         $error("halted dropped without a reset");
         failures++;
      end

   quietAfterHalt: assert property (@(posedge clk) disable iff (reset) halted |-> !retireValid)
      else begin
         $error("register write retired after halt");
         failures++;
      end

   errSticky: assert property (@(posedge clk) disable iff (reset) err |=> err)
      else begin
         $error("err cleared without a reset");
         failures++;
      end

   errNeedsIllegal: assert property (@(posedge clk) disable iff (reset) !(|illegalAt) |-> !err)
      else begin
         $error("err set with no illegal opcode loaded");
         failures++;
      end

endmodule

bind proc procProps propsCheck (
   .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
   .progData(progData), .retireValid(retireValid), .halted(halted), .err(err)
);

//--- proc.sv
/*
 * Top level of the five-stage processor. Connects the four stage
 * modules, the last of which ends in the writeback register.
 */
`timescale 1ns/1ps
`default_nettype none
module proc (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 progWrite,
   input  procIsaPkg::pcAddr   progAddr,
   input  procIsaPkg::word     progData,
   output logic                retireValid,
   output procIsaPkg::regIdx   retireReg,
   output procIsaPkg::word     retireData,
   output logic                halted,
   output logic                err
);

   procPipePkg::fetchOut   fetchOut;
   procPipePkg::decodeOut  decodeOut;
   procPipePkg::executeOut executeOut;
   procPipePkg::retireOut  retireOut;
   procPipePkg::bypass     memBypass;
   procPipePkg::bypass     wbBypass;
   procPipePkg::redirect   redirect;
   logic                   stall;

   fetchStage fetchSection (.clk(clk), .reset(reset), .progWrite(progWrite),
      .progAddr(progAddr), .progData(progData), .stall(stall), .redirect(redirect),
      .fetchOut(fetchOut));

   decodeStage decodeSection (.clk(clk), .reset(reset), .fetchOut(fetchOut),
      .redirect(redirect), .retireOut(retireOut), .memBypass(memBypass),
      .decodeOut(decodeOut), .stall(stall), .wbBypass(wbBypass), .err(err));

   executeStage executeSection (.clk(clk), .reset(reset), .decodeOut(decodeOut),
      .memBypass(memBypass), .wbBypass(wbBypass), .executeOut(executeOut),
      .redirect(redirect));

   memoryStage memorySection (.clk(clk), .reset(reset), .executeOut(executeOut),
      .retireOut(retireOut), .memBypass(memBypass), .halted(halted));

   // One retire pulse per register write
   assign retireValid = retireOut.wrEn;
   assign retireReg   = retireOut.rd;
   assign retireData  = retireOut.data;

endmodule
`default_nettype wire

//--- memoryStage.sv
/*
 * Memory stage: data memory, writeback data selection and the
 * memory-to-writeback register. Raises halted once a HALT is registered.
 */
`timescale 1ns/1ps
`default_nettype none
module memoryStage (
   input  wire                      clk,
   input  wire                      reset,
   input  procPipePkg::executeOut   executeOut,
   output procPipePkg::retireOut    retireOut,
   output procPipePkg::bypass       memBypass,
   output logic                     halted
);

   procIsaPkg::word     dmem [procIsaPkg::DMEM_DEPTH];
   procIsaPkg::dataAddr addr;
   procIsaPkg::word     wbData;
   logic                isLoad;
   logic                haltLatch;

   assign addr   = executeOut.result[7:0];
   assign isLoad = executeOut.op == procIsaPkg::LD;
   assign wbData = isLoad ? dmem[addr] : executeOut.result;

   always_ff @(posedge clk) begin
      if (executeOut.valid && executeOut.op == procIsaPkg::ST) begin
         dmem[addr] <= executeOut.storeData;
      end
   end

   // Load data reaches execute only through the writeback bypass
   assign memBypass = '{wrEn: executeOut.valid && executeOut.wrEn && !isLoad,
                        rd: executeOut.rd, value: executeOut.result};

   always_ff @(posedge clk) begin
      if (reset) begin
         retireOut.valid <= 1'b0;
         retireOut.wrEn <= 1'b0;
         retireOut.halt <= 1'b0;
         haltLatch <= 1'b0;
      end else begin
         retireOut.valid <= executeOut.valid;
         retireOut.wrEn <= executeOut.valid && executeOut.wrEn;
         retireOut.halt <= executeOut.valid && executeOut.op == procIsaPkg::HALT;
         if (retireOut.valid && retireOut.halt) begin
            haltLatch <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      retireOut.rd   <= executeOut.rd;
      retireOut.data <= wbData;
   end

   assign halted = haltLatch || (retireOut.valid && retireOut.halt);

endmodule
`default_nettype wire

//--- executeStage.sv
/*
 * Execute stage: operand forwarding from memory and writeback, the ALU,
 * BEQZ resolution with redirect, and the execute-to-memory register.
 */
`timescale 1ns/1ps
`default_nettype none
module executeStage (
   input  wire                      clk,
   input  wire                      reset,
   input  procPipePkg::decodeOut    decodeOut,
   input  procPipePkg::bypass       memBypass,
   input  procPipePkg::bypass       wbBypass,
   output procPipePkg::executeOut   executeOut,
   output procPipePkg::redirect     redirect
);

   procIsaPkg::word opA;
   procIsaPkg::word opB;
   procIsaPkg::word result;

   // Memory stage holds the newer result
   assign opA = procPipePkg::pickOperand(decodeOut.rs, decodeOut.rsVal, memBypass, wbBypass);
   assign opB = procPipePkg::pickOperand(decodeOut.rt, decodeOut.rtVal, memBypass, wbBypass);

   always_comb begin
      case (decodeOut.op)
         procIsaPkg::ADD:  result = opA + opB;
         procIsaPkg::SUB:  result = opA - opB;
         procIsaPkg::AND:  result = opA & opB;
         procIsaPkg::XOR:  result = opA ^ opB;
         // Address for LD and ST
         procIsaPkg::ADDI, procIsaPkg::LD, procIsaPkg::ST: result = opA + decodeOut.imm;
         procIsaPkg::LI:   result = decodeOut.imm;
         default:          result = '0;
      endcase
   end

   // Branch target is relative to the next PC and wraps in the 8-bit space
   assign redirect.taken  = decodeOut.valid && decodeOut.op == procIsaPkg::BEQZ && opA == '0;
   assign redirect.target = decodeOut.nextPc + decodeOut.imm[7:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         executeOut.valid <= 1'b0;
      end else begin
         executeOut.valid <= decodeOut.valid;
      end
   end

   always_ff @(posedge clk) begin
      executeOut.op        <= decodeOut.op;
      executeOut.rd        <= decodeOut.rd;
      executeOut.wrEn      <= decodeOut.wrEn;
      executeOut.result    <= result;
      executeOut.storeData <= opB;
   end

endmodule
`default_nettype wire

//--- decodeStage.sv
/*
 * Decode stage: register file written from writeback, control decode,
 * load-use stall, sticky illegal-opcode error and the decode-to-execute
 * register. Also offers the writeback bypass to execute.
 */
`timescale 1ns/1ps
`default_nettype none
module decodeStage (
   input  wire                      clk,
   input  wire                      reset,
   input  procPipePkg::fetchOut     fetchOut,
   input  procPipePkg::redirect     redirect,
   input  procPipePkg::retireOut    retireOut,
   input  procPipePkg::bypass       memBypass,
   output procPipePkg::decodeOut    decodeOut,
   output logic                     stall,
   output procPipePkg::bypass       wbBypass,
   output logic                     err
);

   procIsaPkg::word   regs [procIsaPkg::REG_COUNT];
   procIsaPkg::word   instr;
   procIsaPkg::opcode op;
   procIsaPkg::regIdx rdIdx;
   procIsaPkg::regIdx rsIdx;
   procIsaPkg::regIdx rtIdx;
   procIsaPkg::word   immExt;
   procIsaPkg::word   rsVal;
   procIsaPkg::word   rtVal;
   logic              useA;
   logic              useB;
   logic              wrEn;
   logic              illegal;
   logic              loadUse;
   logic              wbWrite;

   assign instr = fetchOut.instr;
   assign op    = procIsaPkg::opcode'(instr[procIsaPkg::OP_HI:procIsaPkg::OP_LO]);
   assign rdIdx = instr[procIsaPkg::RD_HI:procIsaPkg::RD_LO];
   assign rsIdx = instr[procIsaPkg::RS_HI:procIsaPkg::RS_LO];
   // ST keeps its data register in the rd field
   assign rtIdx = (op == procIsaPkg::ST) ? rdIdx : instr[procIsaPkg::RT_HI:procIsaPkg::RT_LO];

   always_comb begin
      useA = 1'b0;
      useB = 1'b0;
      wrEn = 1'b0;
      illegal = 1'b0;
      case (op)
         procIsaPkg::ADD, procIsaPkg::SUB, procIsaPkg::AND, procIsaPkg::XOR: begin
            useA = 1'b1;
            useB = 1'b1;
            wrEn = 1'b1;
         end
         procIsaPkg::ADDI, procIsaPkg::LD: begin
            useA = 1'b1;
            wrEn = 1'b1;
         end
         procIsaPkg::LI:   wrEn = 1'b1;
         procIsaPkg::ST: begin
            useA = 1'b1;
            useB = 1'b1;
         end
         procIsaPkg::BEQZ: useA = 1'b1;
         procIsaPkg::HALT: useA = 1'b0;
         default:          illegal = 1'b1;
      endcase
   end

   // LI is zero-extended while the rest take the signed 6-bit field
   assign immExt = (op == procIsaPkg::LI) ?
      {8'h00, instr[procIsaPkg::IMM8_HI:0]} :
      {{10{instr[procIsaPkg::IMM6_HI]}}, instr[procIsaPkg::IMM6_HI:0]};

   // A register read in the write cycle sees the new value
   assign wbWrite  = retireOut.valid && retireOut.wrEn;
   assign wbBypass = '{wrEn: wbWrite, rd: retireOut.rd, value: retireOut.data};

   always_ff @(posedge clk) begin
      if (wbWrite) begin
         regs[retireOut.rd] <= retireOut.data;
      end
   end

   assign rsVal = procPipePkg::pickOperand(rsIdx, regs[rsIdx], memBypass, wbBypass);
   assign rtVal = procPipePkg::pickOperand(rtIdx, regs[rtIdx], memBypass, wbBypass);

   // Load in execute feeding this instruction costs one bubble
   assign loadUse = decodeOut.valid && decodeOut.op == procIsaPkg::LD &&
      ((useA && decodeOut.rd == rsIdx) || (useB && decodeOut.rd == rtIdx));
   assign stall = fetchOut.valid && loadUse;

   always_ff @(posedge clk) begin
      if (reset) begin
         decodeOut.valid <= 1'b0;
         err <= 1'b0;
      end else begin
         decodeOut.valid <= fetchOut.valid && !redirect.taken && !stall && !illegal;
         if (fetchOut.valid && !redirect.taken && illegal) begin
            err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      decodeOut.op     <= op;
      decodeOut.rd     <= rdIdx;
      decodeOut.rs     <= rsIdx;
      decodeOut.rt     <= rtIdx;
      decodeOut.rsVal  <= rsVal;
      decodeOut.rtVal  <= rtVal;
      decodeOut.imm    <= immExt;
      decodeOut.nextPc <= fetchOut.nextPc;
      decodeOut.wrEn   <= wrEn;
   end

endmodule
`default_nettype wire

//--- fetchStage.sv
/*
 * Fetch stage: PC, instruction memory with its program load port and the
 * fetch-to-decode register. Holds on stall, jumps on a redirect and stops
 * for good once a HALT reaches decode.
 */
`timescale 1ns/1ps
`default_nettype none
module fetchStage (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      progWrite,
   input  procIsaPkg::pcAddr        progAddr,
   input  procIsaPkg::word          progData,
   input  wire                      stall,
   input  procPipePkg::redirect     redirect,
   output procPipePkg::fetchOut     fetchOut
);

   procIsaPkg::word   imem [procIsaPkg::IMEM_DEPTH];
   procIsaPkg::pcAddr pc;
   logic              haltSeen;
   logic              haltInDecode;
   logic              freeze;

   // Loaded by the testbench while reset is held
   always_ff @(posedge clk) begin
      if (progWrite) begin
         imem[progAddr] <= progData;
      end
   end

   assign haltInDecode = fetchOut.valid &&
      (procIsaPkg::opcode'(fetchOut.instr[procIsaPkg::OP_HI:procIsaPkg::OP_LO]) ==
       procIsaPkg::HALT);

   // Nothing younger than a HALT is ever fetched
   assign freeze = haltSeen || haltInDecode;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         haltSeen <= 1'b0;
         fetchOut.valid <= 1'b0;
      end else if (redirect.taken) begin
         // Taken branch kills whatever sits in decode
         pc <= redirect.target;
         fetchOut.valid <= 1'b0;
      end else if (!stall) begin
         if (freeze) begin
            fetchOut.valid <= 1'b0;
         end else begin
            fetchOut.valid <= 1'b1;
            fetchOut.instr <= imem[pc];
            fetchOut.nextPc <= pc + 1'b1;
            pc <= pc + 1'b1;
         end
         if (haltInDecode) begin
            haltSeen <= 1'b1;
         end
      end
   end

endmodule
`default_nettype wire

//--- procPipePkg.sv
/*
 * Stage-to-stage records of the pipeline plus the forwarding and
 * redirect types. Each stage registers one of these structs.
 */
package procPipePkg;

   typedef struct packed {
      logic               valid;
      procIsaPkg::word    instr;
      procIsaPkg::pcAddr  nextPc;
   } fetchOut;

   typedef struct packed {
      logic               valid;
      procIsaPkg::opcode  op;
      procIsaPkg::regIdx  rd;
      procIsaPkg::regIdx  rs;
      // Second source which is the data register for ST
      procIsaPkg::regIdx  rt;
      procIsaPkg::word    rsVal;
      procIsaPkg::word    rtVal;
      procIsaPkg::word    imm;
      procIsaPkg::pcAddr  nextPc;
      logic               wrEn;
   } decodeOut;

   typedef struct packed {
      logic               valid;
      procIsaPkg::opcode  op;
      procIsaPkg::regIdx  rd;
      logic               wrEn;
      procIsaPkg::word    result;
      procIsaPkg::word    storeData;
   } executeOut;

   typedef struct packed {
      logic               valid;
      procIsaPkg::regIdx  rd;
      logic               wrEn;
      procIsaPkg::word    data;
      logic               halt;
   } retireOut;

   // A result offered by a later stage when wrEn is high
   typedef struct packed {
      logic               wrEn;
      procIsaPkg::regIdx  rd;
      procIsaPkg::word    value;
   } bypass;

   typedef struct packed {
      logic               taken;
      procIsaPkg::pcAddr  target;
   } redirect;

   // Newer bypass wins over older one before the register value
   function automatic procIsaPkg::word pickOperand(
      input procIsaPkg::regIdx idx,
      input procIsaPkg::word   regVal,
      input bypass             newer,
      input bypass             older
   );
      if (newer.wrEn && newer.rd == idx) return newer.value;
      if (older.wrEn && older.rd == idx) return older.value;
      return regVal;
   endfunction

endpackage

//--- procIsaPkg.sv
/*
 * Instruction set of the 16-bit pipelined processor: widths, opcodes,
 * field positions and memory sizes. Stages refer to it by scoped names.
 */
package procIsaPkg;

   localparam int WORD_W = 16;
   localparam int REG_COUNT = 8;
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;

   // Instruction field positions
   localparam int OP_HI = 15;
   localparam int OP_LO = 12;
   localparam int RD_HI = 11;
   localparam int RD_LO = 9;
   localparam int RS_HI = 8;
   localparam int RS_LO = 6;
   localparam int RT_HI = 5;
   localparam int RT_LO = 3;
   localparam int IMM6_HI = 5;
   localparam int IMM8_HI = 7;

   typedef logic [WORD_W-1:0] word;
   typedef logic [2:0] regIdx;
   typedef logic [7:0] pcAddr;
   typedef logic [7:0] dataAddr;

   // Top four bits of the instruction where codes 10 to 15 are illegal
   typedef enum logic [3:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      XOR  = 4'd3,
      ADDI = 4'd4,
      LI   = 4'd5,
      LD   = 4'd6,
      ST   = 4'd7,
      BEQZ = 4'd8,
      HALT = 4'd9
   } opcode;

   // ADD, SUB, AND, XOR:  rd = rs op rt
   // ADDI:                rd = rs + simm6
   // LI:                  rd = zext(imm8)
   // LD:                  rd = dmem[rs + simm6]
   // ST:                  dmem[rs + simm6] = reg in rd field
   // BEQZ:                if rs == 0, pc = pc + 1 + simm6
   // HALT:                stop fetching and drain

endpackage
